// ==== design/gemm_sched_cfg.svh ====
/*
  Width and mask-size macros for the GEMM tile scheduler
*/
`ifndef GEMM_SCHED_CFG_SVH
`define GEMM_SCHED_CFG_SVH

// Problem dimensions ------
`define SCHED_M_W     10  // M dimension, m tile count and index
`define SCHED_N_W     10  // N dimension, n tile count and index
`define SCHED_K_W     12  // K dimension, usually the deepest

// Tile geometry --------
`define SCHED_T_W     6   // Tm, Tn and Tk, also k_idx
`define SCHED_MAX_TM  64  // Rows in the PE array
`define SCHED_MAX_TN  64  // Columns in the PE array

// Status -------------
`define SCHED_PERF_W  32  // Perf counter width

`endif

// ==== design/gemm_sched_pkg.sv ====
/*
  Shared types of the GEMM tile scheduler
  Dimension vectors, enable masks, perf counter and FSM states
*/
`default_nettype none

`include "gemm_sched_cfg.svh"

package gemm_sched_pkg;

  // Dimensions, tile counts and tile indices share one width per axis
  typedef logic [`SCHED_M_W-1:0] m_dim_t;
  typedef logic [`SCHED_N_W-1:0] n_dim_t;
  typedef logic [`SCHED_K_W-1:0] k_dim_t;
  typedef logic [`SCHED_T_W-1:0] tile_sz_t;  // Tile size, effective size, k_idx

  // Bit i set when row or column i is inside the edge tile
  typedef logic [`SCHED_MAX_TM-1:0] row_mask_t;
  typedef logic [`SCHED_MAX_TN-1:0] col_mask_t;

  typedef logic [`SCHED_PERF_W-1:0] perf_cnt_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_PREP_TILE,    // clr pulse, k_tile back to 0
    S_WAIT_READY,   // Stall until both banks valid
    S_LOAD_WEIGHT,  // Weights into the PEs
    S_STREAM_K,     // Activations stream past stationary weights
    S_TILE_DONE,
    S_DONE
  } sched_state_e;

endpackage

`default_nettype wire

// ==== design/tile_walk_if.sv ====
/*
  Strobes and tile indices shared by the FSM, tile walker and edge sizer
*/
`default_nettype none

interface tile_walk_if;
  import gemm_sched_pkg::*;

  // FSM strobes, one cycle each
  logic session_start;  // Clear every index
  logic tile_start;     // New C tile, k back to 0
  logic k_adv;          // Next k-slice, only when last_k is low
  logic tile_adv;       // Step n, wrap into m

  // Walker state
  m_dim_t m_tile;
  n_dim_t n_tile;
  k_dim_t k_tile;
  logic   last_k;
  logic   last_tile;

  modport walker (input session_start, tile_start, k_adv, tile_adv,
                  output m_tile, n_tile, k_tile, last_k, last_tile);
  modport fsm    (output session_start, tile_start, k_adv, tile_adv,
                  input k_tile, last_k, last_tile);
  modport sizer  (input m_tile, n_tile, k_tile);

endinterface

`default_nettype wire

// ==== design/tile_walker.sv ====
/*
  Tile loop nest indices, n inner, m outer, k per tile
  Last-slice and last-tile flags from the host tile counts
*/
`default_nettype none

module tile_walker (
  input wire logic                    clk_gated,
  input wire logic                    rst_n,
  input wire gemm_sched_pkg::m_dim_t  mt,  // ceil(M/Tm)
  input wire gemm_sched_pkg::n_dim_t  nt,  // ceil(N/Tn)
  input wire gemm_sched_pkg::k_dim_t  kt,  // ceil(K/Tk)
  tile_walk_if.walker                 walk
);
  import gemm_sched_pkg::*;

  m_dim_t m_q;
  n_dim_t n_q;
  k_dim_t k_q;
  logic   last_n;
  logic   last_m;

  // Flags --------------
  // Indices stay below the counts, so the +1 never wraps
  assign last_n = (n_q + n_dim_t'(1)) >= nt;
  assign last_m = (m_q + m_dim_t'(1)) >= mt;

  assign walk.last_k    = (k_q + k_dim_t'(1)) >= kt;
  assign walk.last_tile = last_n && last_m;

  // Indices ------------
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      m_q <= '0;
      n_q <= '0;
      k_q <= '0;
    end else if (walk.session_start) begin
      m_q <= '0;  // Fresh job, walk from tile (0,0)
      n_q <= '0;
      k_q <= '0;
    end else begin
      if (walk.tile_start)
        k_q <= '0;
      else if (walk.k_adv)
        k_q <= k_q + k_dim_t'(1);  // FSM already checked last_k

      // Row-major walk, FSM holds tile_adv off after the last tile
      if (walk.tile_adv) begin
        if (last_n) begin
          n_q <= '0;
          m_q <= m_q + m_dim_t'(1);
        end else begin
          n_q <= n_q + n_dim_t'(1);
        end
      end
    end
  end

  assign walk.m_tile = m_q;
  assign walk.n_tile = n_q;
  assign walk.k_tile = k_q;

endmodule

`default_nettype wire

// ==== design/edge_sizer.sv ====
/*
  Effective edge-tile sizes and thermometer row/column enable masks
*/
`default_nettype none

`include "gemm_sched_cfg.svh"

module edge_sizer (
  input wire gemm_sched_pkg::m_dim_t    m_dim,
  input wire gemm_sched_pkg::n_dim_t    n_dim,
  input wire gemm_sched_pkg::k_dim_t    k_dim,
  input wire gemm_sched_pkg::tile_sz_t  tm,
  input wire gemm_sched_pkg::tile_sz_t  tn,
  input wire gemm_sched_pkg::tile_sz_t  tk,
  tile_walk_if.sizer                    walk,
  output gemm_sched_pkg::tile_sz_t      tm_eff,
  output gemm_sched_pkg::tile_sz_t      tn_eff,
  output gemm_sched_pkg::tile_sz_t      tk_eff,
  output gemm_sched_pkg::row_mask_t     row_mask,
  output gemm_sched_pkg::col_mask_t     col_mask
);
  import gemm_sched_pkg::*;

  // Wide enough for K index times Tk, the largest product here
  localparam int EW = `SCHED_K_W + `SCHED_T_W;
  typedef logic [EW-1:0] wide_t;

  // min(tile, dim - idx*tile), zero past the end of the dimension
  function automatic tile_sz_t eff_size(input wide_t dim, input wide_t idx, input tile_sz_t t);
    wide_t off;
    wide_t rem;
    off      = idx * wide_t'(t);
    rem      = (dim > off) ? (dim - off) : '0;
    eff_size = (rem > wide_t'(t)) ? t : tile_sz_t'(rem);
  endfunction

  // Sizes ---------------
  assign tm_eff = eff_size(wide_t'(m_dim), wide_t'(walk.m_tile), tm);
  assign tn_eff = eff_size(wide_t'(n_dim), wide_t'(walk.n_tile), tn);
  assign tk_eff = eff_size(wide_t'(k_dim), wide_t'(walk.k_tile), tk);

  // Masks ---------------
  assign row_mask = ~(row_mask_t'('1) << tm_eff);  // Low tm_eff bits set
  assign col_mask = ~(col_mask_t'('1) << tn_eff);

endmodule

`default_nettype wire

// ==== design/phase_fsm.sv ====
/*
  Scheduling FSM with k counter and ping/pong bank gating
  Drives walker strobes, array controls and perf strobes
*/
`default_nettype none

module phase_fsm (
  input wire logic                      clk_gated,
  input wire logic                      rst_n,
  input wire logic                      start,   // Sampled in idle and done
  input wire logic                      abort,   // Synchronous, wins over everything
  input wire gemm_sched_pkg::tile_sz_t  tk_eff,
  input wire logic                      valid_a_ping,
  input wire logic                      valid_a_pong,
  input wire logic                      valid_b_ping,
  input wire logic                      valid_b_pong,
  tile_walk_if.fsm                      walk,
  output logic                          rd_en,
  output gemm_sched_pkg::tile_sz_t      k_idx,
  output logic                          bank_sel,
  output logic                          clr,
  output logic                          en,
  output logic                          load_weight,
  output logic                          busy,
  output logic                          done_tile,
  output logic                          tile_start,
  output logic                          stream,
  output logic                          waiting
);
  import gemm_sched_pkg::*;

  sched_state_e state;
  sched_state_e state_n;
  tile_sz_t     k_cnt;       // Position inside the load or stream phase
  logic         bank_ready;
  logic         slice_end;   // Last cycle of a phase
  logic         idle_like;

  // Bank gating ---------
  assign bank_sel   = walk.k_tile[0];  // Even k_tile ping, odd pong
  assign bank_ready = bank_sel ? (valid_a_pong && valid_b_pong)
                               : (valid_a_ping && valid_b_ping);
  assign slice_end  = (k_cnt == tk_eff - tile_sz_t'(1));
  assign idle_like  = (state == S_IDLE) || (state == S_DONE);

  // Next state ---------
  always_comb begin
    state_n = state;
    case (state)
      S_IDLE,
      S_DONE:        if (start) state_n = S_PREP_TILE;
      S_PREP_TILE:   state_n = S_WAIT_READY;
      S_WAIT_READY:  if (bank_ready) state_n = S_LOAD_WEIGHT;  // Else stall, rd_en low
      S_LOAD_WEIGHT: if (slice_end) state_n = S_STREAM_K;
      S_STREAM_K: begin
        if (slice_end)
          state_n = walk.last_k ? S_TILE_DONE : S_WAIT_READY;
      end
      S_TILE_DONE:   state_n = walk.last_tile ? S_DONE : S_PREP_TILE;
      default:       state_n = S_IDLE;
    endcase
    if (abort)
      state_n = S_IDLE;
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      state       <= S_IDLE;
      k_cnt       <= '0;
      load_weight <= 1'b0;
    end else begin
      state <= state_n;
      // Count through a phase, restart at 0 for the next one
      if ((state == S_LOAD_WEIGHT || state == S_STREAM_K) && !slice_end)
        k_cnt <= k_cnt + tile_sz_t'(1);
      else
        k_cnt <= '0;
      load_weight <= (state == S_LOAD_WEIGHT);  // Lines up with read data
    end
  end

  // Walker strobes ------
  assign walk.session_start = idle_like && start && !abort;
  assign walk.tile_start    = (state == S_PREP_TILE);
  assign walk.k_adv         = (state == S_STREAM_K) && slice_end && !walk.last_k;
  assign walk.tile_adv      = (state == S_TILE_DONE) && !walk.last_tile;

  // Array controls
  assign rd_en     = (state == S_LOAD_WEIGHT) || (state == S_STREAM_K);
  assign k_idx     = k_cnt;
  assign clr       = (state == S_PREP_TILE);   // One pulse per C tile
  assign en        = (state == S_STREAM_K);
  assign busy      = !idle_like;
  assign done_tile = (state == S_TILE_DONE);

  // Perf strobes
  assign tile_start = (state == S_PREP_TILE);
  assign stream     = (state == S_STREAM_K);
  assign waiting    = (state == S_WAIT_READY);

endmodule

`default_nettype wire

// ==== design/perf_counters.sv ====
/*
  Per-tile stream-cycle and stall-cycle counters
*/
`default_nettype none

module perf_counters (
  input wire logic                  clk_gated,
  input wire logic                  rst_n,
  input wire logic                  tile_start,  // Clears both counters
  input wire logic                  stream,      // Cycle in STREAM_K
  input wire logic                  waiting,     // Cycle in WAIT_READY
  output gemm_sched_pkg::perf_cnt_t cycles_tile,
  output gemm_sched_pkg::perf_cnt_t stall_cycles
);
  import gemm_sched_pkg::*;

  // Values hold once the tile is done, until the next tile_start
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      cycles_tile  <= '0;
      stall_cycles <= '0;
    end else if (tile_start) begin
      cycles_tile  <= '0;
      stall_cycles <= '0;
    end else begin
      if (stream)
        cycles_tile <= cycles_tile + perf_cnt_t'(1);
      if (waiting)
        stall_cycles <= stall_cycles + perf_cnt_t'(1);  // Includes the one-cycle pass
    end
  end

endmodule

`default_nettype wire

// ==== design/gemm_sched.sv ====
/*
  Weight-stationary GEMM tile scheduler top level
  Tile walker, edge sizer, phase FSM and perf counters
*/
`default_nettype none

module gemm_sched (
  input wire logic                      clk_gated,
  input wire logic                      rst_n,
  input wire logic                      start,
  input wire logic                      abort,
  input wire gemm_sched_pkg::m_dim_t    m_dim,
  input wire gemm_sched_pkg::n_dim_t    n_dim,
  input wire gemm_sched_pkg::k_dim_t    k_dim,
  input wire gemm_sched_pkg::tile_sz_t  tm,
  input wire gemm_sched_pkg::tile_sz_t  tn,
  input wire gemm_sched_pkg::tile_sz_t  tk,
  input wire gemm_sched_pkg::m_dim_t    mt,
  input wire gemm_sched_pkg::n_dim_t    nt,
  input wire gemm_sched_pkg::k_dim_t    kt,
  input wire logic                      valid_a_ping,
  input wire logic                      valid_a_pong,
  input wire logic                      valid_b_ping,
  input wire logic                      valid_b_pong,
  output logic                          rd_en,
  output logic                          bank_sel,
  output logic                          clr,
  output logic                          en,
  output logic                          load_weight,
  output logic                          busy,
  output logic                          done_tile,
  output gemm_sched_pkg::tile_sz_t      k_idx,
  output gemm_sched_pkg::row_mask_t     row_mask,
  output gemm_sched_pkg::col_mask_t     col_mask,
  output gemm_sched_pkg::m_dim_t        m_tile,
  output gemm_sched_pkg::n_dim_t        n_tile,
  output gemm_sched_pkg::k_dim_t        k_tile,
  output gemm_sched_pkg::perf_cnt_t     cycles_tile,
  output gemm_sched_pkg::perf_cnt_t     stall_cycles
);
  import gemm_sched_pkg::*;

  tile_sz_t tk_eff;      // Slice depth for the FSM phases
  logic     tile_start;
  logic     stream;
  logic     waiting;

  tile_walk_if walk ();

  // Blocks ------------
  tile_walker u_walker (.clk_gated, .rst_n, .mt, .nt, .kt, .walk(walk.walker));

  edge_sizer u_sizer (.m_dim, .n_dim, .k_dim, .tm, .tn, .tk, .walk(walk.sizer),
                      .tm_eff(), .tn_eff(), .tk_eff, .row_mask, .col_mask);

  phase_fsm u_fsm (.clk_gated, .rst_n, .start, .abort, .tk_eff,
                   .valid_a_ping, .valid_a_pong, .valid_b_ping, .valid_b_pong,
                   .walk(walk.fsm), .rd_en, .k_idx, .bank_sel, .clr, .en,
                   .load_weight, .busy, .done_tile, .tile_start, .stream, .waiting);

  perf_counters u_perf (.clk_gated, .rst_n, .tile_start, .stream, .waiting,
                        .cycles_tile, .stall_cycles);

  // Tile coordinates straight from the walker
  assign m_tile = walk.m_tile;
  assign n_tile = walk.n_tile;
  assign k_tile = walk.k_tile;

endmodule

`default_nettype wire

// ==== sim/sched_model.svh ====
/*
  Reference model for the scheduler testbench
  Tile counts, edge sizes, enable masks, tile order and stall counts
*/
`ifndef SCHED_MODEL_SVH
`define SCHED_MODEL_SVH

// Tiles needed to cover a dimension
function automatic int ceil_div(input int dim, input int t);
  return (dim + t - 1) / t;
endfunction

// Edge tile gets only what is left of the dimension
function automatic int eff_size(input int dim, input int idx, input int t);
  int rest;
  rest = dim - idx * t;
  return (rest < t) ? rest : t;
endfunction

// Ones shifted in from bit 0, n of them
function automatic row_mask_t thermo_mask(input int n);
  row_mask_t m;
  m = '0;
  for (int i = 0; i < n; i++)
    m = {m[$bits(row_mask_t)-2:0], 1'b1};
  return m;
endfunction

// Row-major tile order, n inner
task automatic step_tile(inout int m, inout int n, input int nt);
  if (n + 1 == nt) begin
    n = 0;
    m = m + 1;
  end else begin
    n = n + 1;
  end
endtask

// One pass through WAIT_READY per slice, plus every not-ready cycle
function automatic int exp_stall(input int kt, input int not_ready);
  return kt + not_ready;
endfunction

`endif

// ==== sim/gemm_sched_tb.sv ====
/*
  Testbench for the GEMM tile scheduler
  Random jobs with bank back-pressure and aborts, negedge monitor against the model
*/
`default_nettype none

module gemm_sched_tb;
  import gemm_sched_pkg::*;

  `include "sched_model.svh"

  localparam int num_jobs   = 24;
  localparam int job_cycles = 40 * 40 * (2 + 2 * 40 + 4 * 40) + 200;  // All tiles size 1

  logic      clk_gated = 1'b0;
  logic      rst_n, start, abort;
  m_dim_t    m_dim, mt, m_tile;
  n_dim_t    n_dim, nt, n_tile;
  k_dim_t    k_dim, kt, k_tile;
  tile_sz_t  tm, tn, tk, k_idx;
  logic      valid_a_ping, valid_a_pong, valid_b_ping, valid_b_pong;
  logic      rd_en, bank_sel, clr, en, load_weight, busy, done_tile;
  row_mask_t row_mask;
  col_mask_t col_mask;
  perf_cnt_t cycles_tile, stall_cycles;

  int m_len, n_len, k_len, t_m, t_n, t_k, m_cnt, n_cnt, k_cnt;  // Current job
  int job_id, mon_job, exp_m, exp_n, exp_k, tiles_seen, ks, clr_cnt, nr_cnt;
  int idx_err, sz_err, mask_err, cnt_err, ctl_err;
  bit in_stream, prev_load, prev_stall, abort_q, prev_busy, rst_q;
  logic bank_ok, waiting;
  int unsigned gap [2];   // Low cycles left, 0 ping 1 pong
  logic [1:0]  low [2];   // Bit 0 drops A, bit 1 drops B

  always #5 clk_gated = ~clk_gated;

  gemm_sched gemm_sched_i (.*);

  // Compare tasks --------------
  task automatic check_sz(input string what, input tile_sz_t want, input tile_sz_t got);
    if (got !== want) begin
      sz_err++;
      $display("Error job %0d %s: expected %0d actual %0d", job_id, what, want, got);
    end
  endtask

  task automatic check_idx(input string what, input m_dim_t want, input m_dim_t got);
    if (got !== want) begin
      idx_err++;
      $display("Error job %0d %s: expected %0d actual %0d", job_id, what, want, got);
    end
  endtask

  task automatic check_ktile(input string what, input k_dim_t want, input k_dim_t got);
    if (got !== want) begin
      idx_err++;
      $display("Error job %0d %s: expected %0d actual %0d", job_id, what, want, got);
    end
  endtask

  task automatic check_mask(input string what, input row_mask_t want, input row_mask_t got);
    if (got !== want) begin
      mask_err++;
      $display("Error job %0d %s: expected %h actual %h", job_id, what, want, got);
    end
  endtask

  task automatic check_cnt(input string what, input perf_cnt_t want, input perf_cnt_t got);
    if (got !== want) begin
      cnt_err++;
      $display("Error job %0d %s: expected %0d actual %0d", job_id, what, want, got);
    end
  endtask

  task automatic check_bit(input string what, input logic want, input logic got);
    if (got !== want) begin
      ctl_err++;
      $display("Error job %0d %s: expected %b actual %b", job_id, what, want, got);
    end
  endtask

  // Stimulus -------------------
  task automatic run_job(input bit abort_mid);
    @(posedge clk_gated);
    m_len = 1 + $urandom % 40;
    n_len = 1 + $urandom % 40;
    k_len = 1 + $urandom % 40;
    t_m   = 1 + $urandom % 8;
    t_n   = 1 + $urandom % 8;
    t_k   = 1 + $urandom % 8;
    m_cnt = ceil_div(m_len, t_m);
    n_cnt = ceil_div(n_len, t_n);
    k_cnt = ceil_div(k_len, t_k);
    m_dim <= m_dim_t'(m_len);
    n_dim <= n_dim_t'(n_len);
    k_dim <= k_dim_t'(k_len);
    tm    <= tile_sz_t'(t_m);
    tn    <= tile_sz_t'(t_n);
    tk    <= tile_sz_t'(t_k);
    mt    <= m_dim_t'(m_cnt);
    nt    <= n_dim_t'(n_cnt);
    kt    <= k_dim_t'(k_cnt);
    job_id <= job_id + 1;
    start  <= 1'b1;
    @(posedge clk_gated);
    start <= 1'b0;
    if (abort_mid) begin
      repeat (3 + $urandom % 40) @(posedge clk_gated);
      abort <= 1'b1;  // Monitor checks the cycle after
      @(posedge clk_gated);
      abort <= 1'b0;
      repeat (2) @(posedge clk_gated);
    end else begin
      @(negedge clk_gated);
      while (busy)
        @(negedge clk_gated);
    end
  endtask

  // Bank valids drop for 1 to 3 cycles, always followed by a ready cycle
  initial begin
    {valid_a_ping, valid_a_pong, valid_b_ping, valid_b_pong} = 4'hf;
    gap[0] = 0;
    gap[1] = 0;
    forever begin
      @(posedge clk_gated);
      for (int b = 0; b < 2; b++) begin
        if (gap[b] != 0)
          gap[b]--;
        else if ($urandom % 6 == 0) begin
          gap[b] = 1 + $urandom % 3;
          low[b] = 2'(1 + $urandom % 3);
        end
      end
      valid_a_ping <= !(gap[0] != 0 && low[0][0]);
      valid_b_ping <= !(gap[0] != 0 && low[0][1]);
      valid_a_pong <= !(gap[1] != 0 && low[1][0]);
      valid_b_pong <= !(gap[1] != 0 && low[1][1]);
    end
  end

  // Monitor --------------------
  always @(negedge clk_gated) begin
    bank_ok = exp_k[0] ? (valid_a_pong && valid_b_pong) : (valid_a_ping && valid_b_ping);
    waiting = busy && !rd_en && !clr && !done_tile;  // WAIT_READY from outside
    if (rst_n && !rst_q)
      check_bit("busy after reset", 1'b0, busy);
    if (rst_n && rst_q) begin
      if (job_id != mon_job) begin  // New job, model walk from (0,0)
        mon_job    = job_id;
        exp_m      = 0;
        exp_n      = 0;
        tiles_seen = 0;
      end
      if (rd_en || waiting) begin  // Slice index and bank from the model walk
        check_ktile("k_tile", k_dim_t'(exp_k), k_tile);
        check_bit("bank_sel", exp_k[0], bank_sel);
      end
      check_bit("load_weight", prev_load, load_weight);  // Load stretch one cycle late
      if (prev_stall)
        check_bit("rd_en after stall", 1'b0, rd_en);
      if (abort_q) begin
        check_bit("busy after abort", 1'b0, busy);
        check_bit("rd_en after abort", 1'b0, rd_en);
        check_bit("en after abort", 1'b0, en);
      end
      if (clr) begin
        clr_cnt++;
        nr_cnt = 0;
        exp_k  = 0;
      end
      if (waiting && !bank_ok)
        nr_cnt++;
      if (rd_en) begin
        check_sz("k_idx", tile_sz_t'(ks), k_idx);
        check_bit("en phase", in_stream, en);
        ks++;
        if (ks >= eff_size(k_len, exp_k, t_k)) begin  // Stretch of effective Tk
          ks = 0;
          if (in_stream)
            exp_k++;  // Slice done, walker moves to the next k
          in_stream = !in_stream;
        end
      end else if (busy) begin
        check_bit("slice phases complete", 1'b1, ks == 0 && !in_stream);
        ks        = 0;
        in_stream = 1'b0;
      end
      if (done_tile) begin
        check_idx("m_tile", m_dim_t'(exp_m), m_tile);
        check_idx("n_tile", m_dim_t'(exp_n), m_dim_t'(n_tile));
        check_mask("row_mask", thermo_mask(eff_size(m_len, exp_m, t_m)), row_mask);
        check_mask("col_mask", thermo_mask(eff_size(n_len, exp_n, t_n)),
                   row_mask_t'(col_mask));
        check_cnt("cycles_tile", perf_cnt_t'(k_len), cycles_tile);  // Whole K per tile
        check_cnt("stall_cycles", perf_cnt_t'(exp_stall(k_cnt, nr_cnt)), stall_cycles);
        check_cnt("clr pulses", perf_cnt_t'(1), perf_cnt_t'(clr_cnt));
        tiles_seen++;
        step_tile(exp_m, exp_n, n_cnt);
        clr_cnt = 0;
      end
      if (prev_busy && !busy && !abort_q)
        check_cnt("tile count", perf_cnt_t'(m_cnt * n_cnt), perf_cnt_t'(tiles_seen));
      if (!busy) begin
        ks        = 0;
        in_stream = 1'b0;
        clr_cnt   = 0;
        exp_k     = 0;
      end
    end
    rst_q      = rst_n;
    prev_load  = rd_en && !en;
    prev_stall = waiting && !bank_ok;
    abort_q    = abort;
    prev_busy  = busy;
  end

  // Main sequence --------------
  initial begin
    void'($urandom(32'hd7907ccc));
    rst_n  = 1'b0;
    start  = 1'b0;
    abort  = 1'b0;
    job_id = 0;
    {m_dim, n_dim, k_dim, mt, nt, kt, tm, tn, tk} = '0;
    repeat (2) @(posedge clk_gated);
    rst_n <= 1'b1;
    for (int j = 0; j < num_jobs; j++) begin
      if (j % 4 == 3)
        run_job(1'b1);  // Aborted job, then a full one
      run_job(1'b0);
    end
    @(posedge clk_gated);
    $display("errors: index %0d size %0d mask %0d count %0d control %0d",
             idx_err, sz_err, mask_err, cnt_err, ctl_err);
    if (idx_err + sz_err + mask_err + cnt_err + ctl_err == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog, bound from the worst-case job length
  initial begin
    repeat (num_jobs * job_cycles) @(posedge clk_gated);
    $display("Watchdog expired, the scheduler did not finish its jobs in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== gemm_sched.f ====
+incdir+design
+incdir+sim
design/gemm_sched_pkg.sv
design/tile_walk_if.sv
design/tile_walker.sv
design/edge_sizer.sv
design/phase_fsm.sv
design/perf_counters.sv
design/gemm_sched.sv
sim/gemm_sched_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the gemm_sched testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module gemm_sched_tb \
  -f gemm_sched.f -o gemm_sched_sim
./obj_dir/gemm_sched_sim > sim.log
cat sim.log

# Simulation exits normally either way, the log decides
if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
